/* flist.f */
+incdir+hw
hw/mem_subsys_pkg.sv
hw/ahb_lite_if.sv
hw/dmem_ahb_bridge.sv
hw/imem_ahb_bridge.sv
hw/ahb_dual_port_ram.sv
hw/mem_subsys.sv
testbench/dmem_bridge_checker.sv
testbench/mem_subsys_tb.sv

/* hw/ahb_dual_port_ram.sv */
/*
 * Dual-port AHB-Lite RAM
 * Port A serves fetches and port B serves loads and stores, both from one array
 */
`timescale 1ns/1ps
`include "mem_subsys_cfg.svh"

module ahb_dual_port_ram (
    input logic       clk,
    input logic       rst_n,
    ahb_lite_if.slave port_a,
    ahb_lite_if.slave port_b
);

    localparam int LANES = `MEM_SUBSYS_AHB_WIDTH / 8;
    localparam int OFS_W = $clog2(LANES);
    localparam int IDX_W = $clog2(`MEM_SUBSYS_RAM_WORDS);
    localparam mem_subsys_pkg::bus_word_t TOP_ADDR =
        mem_subsys_pkg::bus_word_t'(LANES * `MEM_SUBSYS_RAM_WORDS);

    typedef logic [IDX_W-1:0] word_idx_t;
    typedef logic [LANES-1:0] lane_mask_t;

    function automatic lane_mask_t lane_mask(
        input mem_subsys_pkg::hsize_e size,
        input logic [OFS_W-1:0]       lane
    );
        case (size)
            mem_subsys_pkg::SIZE_8B:  return lane_mask_t'(1) << lane;
            mem_subsys_pkg::SIZE_16B: return lane_mask_t'(3) << {lane[OFS_W-1:1], 1'b0};
            default:                  return '1;
        endcase
    endfunction

    mem_subsys_pkg::bus_word_t mem [`MEM_SUBSYS_RAM_WORDS];

    // Address-phase registers
    logic       a_act;
    word_idx_t  a_idx;
    logic       a_write;
    logic       a_err;
    logic       b_act;
    word_idx_t  b_idx;
    lane_mask_t b_mask;
    logic       b_write;
    logic       b_err;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            a_act <= 1'b0;
            b_act <= 1'b0;
        end else begin
            a_act <= (port_a.htrans == mem_subsys_pkg::NONSEQ);
            b_act <= (port_b.htrans == mem_subsys_pkg::NONSEQ);
        end
    end

    always_ff @(posedge clk) begin
        if (port_a.htrans == mem_subsys_pkg::NONSEQ) begin
            a_idx   <= port_a.haddr[IDX_W+OFS_W-1:OFS_W];
            a_write <= port_a.hwrite;
            a_err   <= (port_a.haddr >= TOP_ADDR);
        end
        if (port_b.htrans == mem_subsys_pkg::NONSEQ) begin
            b_idx   <= port_b.haddr[IDX_W+OFS_W-1:OFS_W];
            b_mask  <= lane_mask(port_b.hsize, port_b.haddr[OFS_W-1:0]);
            b_write <= port_b.hwrite;
            b_err   <= (port_b.haddr >= TOP_ADDR);
        end
    end

    // ----------------------------------------------------------------------
    // Store commits at the end of the data phase
    // ----------------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (b_act && b_write && !b_err) begin
            for (int i = 0; i < LANES; i++) begin
                if (b_mask[i]) begin
                    mem[b_idx][8*i +: 8] <= port_b.hwdata[8*i +: 8];
                end
            end
        end
    end

    // Zero wait states on both ports
    assign port_a.hready = 1'b1;
    assign port_b.hready = 1'b1;

    // Port A is fetch-only so a write there is refused
    assign port_a.hresp  = (a_act && (a_err || a_write)) ? mem_subsys_pkg::ERROR
                                                         : mem_subsys_pkg::OKAY;
    assign port_b.hresp  = (b_act && b_err) ? mem_subsys_pkg::ERROR
                                            : mem_subsys_pkg::OKAY;

    // Reads see the array before this cycle's store
    assign port_a.hrdata = mem[a_idx];
    assign port_b.hrdata = mem[b_idx];

endmodule

/* hw/ahb_lite_if.sv */
/*
 * AHB-Lite bus between one bridge and one RAM port
 * Single transfers only, no bursts or locking
 */
`timescale 1ns/1ps

interface ahb_lite_if;

    mem_subsys_pkg::bus_word_t haddr;
    logic                      hwrite;
    mem_subsys_pkg::hsize_e    hsize;
    mem_subsys_pkg::htrans_e   htrans;
    mem_subsys_pkg::bus_word_t hwdata;
    mem_subsys_pkg::bus_word_t hrdata;
    logic                      hready;
    mem_subsys_pkg::hresp_e    hresp;

    modport master (
        output haddr, hwrite, hsize, htrans, hwdata,
        input  hrdata, hready, hresp
    );

    modport slave (
        input  haddr, hwrite, hsize, htrans, hwdata,
        output hrdata, hready, hresp
    );

endinterface

/* hw/dmem_ahb_bridge.sv */
/*
 * Data memory bridge
 * Turns core load/store requests into single AHB-Lite transfers, places
 * store data on its byte lanes and extracts load data from the read word
 */
`timescale 1ns/1ps

module dmem_ahb_bridge (
    input  logic                       clk,
    input  logic                       rst_n,
    input  logic                       dmem_req,
    input  mem_subsys_pkg::mem_cmd_e   dmem_cmd,
    input  mem_subsys_pkg::mem_width_e dmem_width,
    input  mem_subsys_pkg::bus_word_t  dmem_addr,
    input  mem_subsys_pkg::bus_word_t  dmem_wdata,
    output logic                       dmem_req_ack,
    output mem_subsys_pkg::bus_word_t  dmem_rdata,
    output mem_subsys_pkg::mem_resp_e  dmem_resp,
    ahb_lite_if.master                 bus
);

    // ----------------------------------------------------------------------
    // Width and lane conversion
    // ----------------------------------------------------------------------
    function automatic mem_subsys_pkg::hsize_e to_hsize(
        input mem_subsys_pkg::mem_width_e width
    );
        case (width)
            mem_subsys_pkg::BYTE:  return mem_subsys_pkg::SIZE_8B;
            mem_subsys_pkg::HWORD: return mem_subsys_pkg::SIZE_16B;
            default:               return mem_subsys_pkg::SIZE_32B;
        endcase
    endfunction

    function automatic mem_subsys_pkg::bus_word_t place_wdata(
        input mem_subsys_pkg::mem_width_e width,
        input logic [1:0]                 lane,
        input mem_subsys_pkg::bus_word_t  wdata
    );
        case (width)
            mem_subsys_pkg::BYTE:
                return mem_subsys_pkg::bus_word_t'(wdata[7:0]) << {lane, 3'b000};
            mem_subsys_pkg::HWORD:
                return mem_subsys_pkg::bus_word_t'(wdata[15:0]) << {lane[1], 4'b0000};
            default:
                return wdata;
        endcase
    endfunction

    // Shift the addressed lane down and zero-extend
    function automatic mem_subsys_pkg::bus_word_t extract_rdata(
        input mem_subsys_pkg::hsize_e    size,
        input logic [1:0]                lane,
        input mem_subsys_pkg::bus_word_t rdata
    );
        mem_subsys_pkg::bus_word_t byte_sh;
        mem_subsys_pkg::bus_word_t half_sh;
        byte_sh = rdata >> {lane, 3'b000};
        half_sh = rdata >> {lane[1], 4'b0000};
        case (size)
            mem_subsys_pkg::SIZE_8B:  return mem_subsys_pkg::bus_word_t'(byte_sh[7:0]);
            mem_subsys_pkg::SIZE_16B: return mem_subsys_pkg::bus_word_t'(half_sh[15:0]);
            default:                  return rdata;
        endcase
    endfunction

    mem_subsys_pkg::bridge_fsm_e fsm;
    logic                        buf_full;
    logic                        buf_empty;
    logic                        buf_wr;
    logic                        buf_rd;
    logic                        issue;
    logic                        data_done;
    logic                        data_ok;

    // Request as it arrives, as buffered, and the one presented to the bus
    logic                        new_write;
    mem_subsys_pkg::hsize_e      new_size;
    mem_subsys_pkg::bus_word_t   new_wdata;
    logic                        buf_write;
    mem_subsys_pkg::hsize_e      buf_size;
    mem_subsys_pkg::bus_word_t   buf_addr;
    mem_subsys_pkg::bus_word_t   buf_wdata;
    logic                        cur_write;
    mem_subsys_pkg::hsize_e      cur_size;
    mem_subsys_pkg::bus_word_t   cur_addr;
    mem_subsys_pkg::bus_word_t   cur_wdata;

    // Transfer in its data phase
    logic [1:0]                  dp_lane;
    mem_subsys_pkg::hsize_e      dp_size;
    mem_subsys_pkg::bus_word_t   dp_wdata;

    // ----------------------------------------------------------------------
    // One-entry request buffer, bypassed when empty
    // ----------------------------------------------------------------------
    assign dmem_req_ack = !buf_full;
    assign buf_wr       = dmem_req && !buf_full;
    assign buf_empty    = !(buf_full || dmem_req);

    assign new_write = (dmem_cmd == mem_subsys_pkg::WR);
    assign new_size  = to_hsize(dmem_width);
    assign new_wdata = place_wdata(dmem_width, dmem_addr[1:0], dmem_wdata);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            buf_full <= 1'b0;
        end else if (!buf_full) begin
            buf_full <= dmem_req && !buf_rd;
        end else begin
            buf_full <= !buf_rd;
        end
    end

    always_ff @(posedge clk) begin
        if (buf_wr && !buf_rd) begin
            buf_write <= new_write;
            buf_size  <= new_size;
            buf_addr  <= dmem_addr;
            buf_wdata <= new_wdata;
        end
    end

    assign cur_write = buf_full ? buf_write : new_write;
    assign cur_size  = buf_full ? buf_size  : new_size;
    assign cur_addr  = buf_full ? buf_addr  : dmem_addr;
    assign cur_wdata = buf_full ? buf_wdata : new_wdata;

    // ----------------------------------------------------------------------
    // Address/data FSM
    // ----------------------------------------------------------------------
    assign data_done = (fsm == mem_subsys_pkg::DATA) && bus.hready;
    assign data_ok   = data_done && (bus.hresp == mem_subsys_pkg::OKAY);

    // An error stops pipelining for one cycle
    assign issue  = !buf_empty && ((fsm == mem_subsys_pkg::ADDR) || data_ok);
    assign buf_rd = issue;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            fsm <= mem_subsys_pkg::ADDR;
        end else if ((fsm == mem_subsys_pkg::ADDR) || data_done) begin
            fsm <= issue ? mem_subsys_pkg::DATA : mem_subsys_pkg::ADDR;
        end
    end

    always_ff @(posedge clk) begin
        if (issue) begin
            dp_lane  <= cur_addr[1:0];
            dp_size  <= cur_size;
            dp_wdata <= cur_wdata;
        end
    end

    assign bus.htrans = issue ? mem_subsys_pkg::NONSEQ : mem_subsys_pkg::IDLE;
    assign bus.haddr  = cur_addr;
    assign bus.hwrite = cur_write;
    assign bus.hsize  = cur_size;
    assign bus.hwdata = dp_wdata;

    // Response for the single cycle of the data phase
    always_comb begin
        if (!data_done) begin
            dmem_resp = mem_subsys_pkg::NOTRDY;
        end else if (bus.hresp == mem_subsys_pkg::OKAY) begin
            dmem_resp = mem_subsys_pkg::RDY_OK;
        end else begin
            dmem_resp = mem_subsys_pkg::RDY_ER;
        end
    end

    assign dmem_rdata = extract_rdata(dp_size, dp_lane, bus.hrdata);

endmodule

/* hw/imem_ahb_bridge.sv */
/*
 * Instruction memory bridge
 * Turns core fetch requests into single AHB-Lite word reads
 */
`timescale 1ns/1ps

module imem_ahb_bridge (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      imem_req,
    input  mem_subsys_pkg::bus_word_t imem_addr,
    output logic                      imem_req_ack,
    output mem_subsys_pkg::bus_word_t imem_rdata,
    output mem_subsys_pkg::mem_resp_e imem_resp,
    ahb_lite_if.master                bus
);

    mem_subsys_pkg::bridge_fsm_e fsm;
    logic                        buf_full;
    logic                        buf_empty;
    logic                        buf_rd;
    logic                        issue;
    logic                        data_done;
    mem_subsys_pkg::bus_word_t   buf_addr;

    // One-entry address buffer
    assign imem_req_ack = !buf_full;
    assign buf_empty    = !(buf_full || imem_req);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            buf_full <= 1'b0;
        end else if (!buf_full) begin
            buf_full <= imem_req && !buf_rd;
        end else begin
            buf_full <= !buf_rd;
        end
    end

    always_ff @(posedge clk) begin
        if (!buf_full && imem_req && !buf_rd) begin
            buf_addr <= imem_addr;
        end
    end

    // FSM returns to ADDR after an error before the next fetch goes out
    assign data_done = (fsm == mem_subsys_pkg::DATA) && bus.hready;
    assign issue     = !buf_empty && ((fsm == mem_subsys_pkg::ADDR) ||
                       (data_done && (bus.hresp == mem_subsys_pkg::OKAY)));
    assign buf_rd    = issue;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            fsm <= mem_subsys_pkg::ADDR;
        end else if ((fsm == mem_subsys_pkg::ADDR) || data_done) begin
            fsm <= issue ? mem_subsys_pkg::DATA : mem_subsys_pkg::ADDR;
        end
    end

    assign bus.htrans = issue ? mem_subsys_pkg::NONSEQ : mem_subsys_pkg::IDLE;
    assign bus.haddr  = buf_full ? buf_addr : imem_addr;
    assign bus.hwrite = 1'b0;
    assign bus.hsize  = mem_subsys_pkg::SIZE_32B;
    assign bus.hwdata = '0;

    always_comb begin
        if (!data_done) begin
            imem_resp = mem_subsys_pkg::NOTRDY;
        end else if (bus.hresp == mem_subsys_pkg::OKAY) begin
            imem_resp = mem_subsys_pkg::RDY_OK;
        end else begin
            imem_resp = mem_subsys_pkg::RDY_ER;
        end
    end

    assign imem_rdata = bus.hrdata;

endmodule

/* hw/mem_subsys.sv */
/*
 * Tightly coupled memory subsystem
 * Instruction and data bridges sharing one dual-port AHB-Lite RAM
 */
`timescale 1ns/1ps

module mem_subsys (
    input  logic                       clk,
    input  logic                       rst_n,
    // Fetch port
    input  logic                       imem_req,
    input  mem_subsys_pkg::bus_word_t  imem_addr,
    output logic                       imem_req_ack,
    output mem_subsys_pkg::bus_word_t  imem_rdata,
    output mem_subsys_pkg::mem_resp_e  imem_resp,
    // Load/store port
    input  logic                       dmem_req,
    input  mem_subsys_pkg::mem_cmd_e   dmem_cmd,
    input  mem_subsys_pkg::mem_width_e dmem_width,
    input  mem_subsys_pkg::bus_word_t  dmem_addr,
    input  mem_subsys_pkg::bus_word_t  dmem_wdata,
    output logic                       dmem_req_ack,
    output mem_subsys_pkg::bus_word_t  dmem_rdata,
    output mem_subsys_pkg::mem_resp_e  dmem_resp
);

    ahb_lite_if imem_bus ();
    ahb_lite_if dmem_bus ();

    imem_ahb_bridge u_imem_bridge (
        .clk          (clk),
        .rst_n        (rst_n),
        .imem_req     (imem_req),
        .imem_addr    (imem_addr),
        .imem_req_ack (imem_req_ack),
        .imem_rdata   (imem_rdata),
        .imem_resp    (imem_resp),
        .bus          (imem_bus.master)
    );

    dmem_ahb_bridge u_dmem_bridge (
        .clk          (clk),
        .rst_n        (rst_n),
        .dmem_req     (dmem_req),
        .dmem_cmd     (dmem_cmd),
        .dmem_width   (dmem_width),
        .dmem_addr    (dmem_addr),
        .dmem_wdata   (dmem_wdata),
        .dmem_req_ack (dmem_req_ack),
        .dmem_rdata   (dmem_rdata),
        .dmem_resp    (dmem_resp),
        .bus          (dmem_bus.master)
    );

    // Port A takes fetches and port B loads and stores
    ahb_dual_port_ram u_ram (
        .clk    (clk),
        .rst_n  (rst_n),
        .port_a (imem_bus.slave),
        .port_b (dmem_bus.slave)
    );

endmodule

/* hw/mem_subsys_cfg.svh */
/*
 * Memory subsystem configuration
 * Bus width and shared RAM depth
 */
`ifndef MEM_SUBSYS_CFG_SVH
`define MEM_SUBSYS_CFG_SVH

// AHB-Lite address and data width in bits
`define MEM_SUBSYS_AHB_WIDTH 32

// Shared RAM depth in words
`define MEM_SUBSYS_RAM_WORDS 256

`endif

/* hw/mem_subsys_pkg.sv */
/*
 * Memory subsystem types
 * Bus word type, core request encodings, AHB-Lite codes and bridge states
 */
`include "mem_subsys_cfg.svh"

package mem_subsys_pkg;

    typedef logic [`MEM_SUBSYS_AHB_WIDTH-1:0] bus_word_t;

    // Core side request and response encodings
    typedef enum logic {
        RD = 1'b0,
        WR = 1'b1
    } mem_cmd_e;

    typedef enum logic [1:0] {
        BYTE  = 2'b00,
        HWORD = 2'b01,
        WORD  = 2'b10
    } mem_width_e;

    typedef enum logic [1:0] {
        NOTRDY = 2'b00,
        RDY_OK = 2'b01,
        RDY_ER = 2'b10
    } mem_resp_e;

    // AHB-Lite codes
    typedef enum logic [2:0] {
        SIZE_8B  = 3'b000,
        SIZE_16B = 3'b001,
        SIZE_32B = 3'b010
    } hsize_e;

    typedef enum logic [1:0] {
        IDLE   = 2'b00,
        NONSEQ = 2'b10
    } htrans_e;

    typedef enum logic {
        OKAY  = 1'b0,
        ERROR = 1'b1
    } hresp_e;

    // Bridge FSM with one transfer in address phase and one in data phase
    typedef enum logic {
        ADDR = 1'b0,
        DATA = 1'b1
    } bridge_fsm_e;

endpackage

/* run_sim.sh */
#!/bin/sh
# Build and run the memory subsystem testbench with Verilator

cd "$(dirname "$0")" &&
verilator --binary --timing --assert --top-module mem_subsys_tb \
    -f flist.f -o sim_mem_subsys &&
./obj_dir/sim_mem_subsys | grep "ALL CHECKS PASSED" &&
echo "Simulation passed" && exit 0 ||
{ echo "Simulation failed"; exit 1; }

/* testbench/dmem_bridge_checker.sv */
/*
 * Data bridge protocol checker, bound into every dmem_ahb_bridge
 */
`timescale 1ns/1ps

module dmem_bridge_checker (
    input logic                      clk,
    input logic                      rst_n,
    input logic                      issue,
    input logic                      dmem_req,
    input logic                      dmem_req_ack,
    input mem_subsys_pkg::mem_resp_e dmem_resp,
    input mem_subsys_pkg::htrans_e   htrans
);

    // Accepted requests still waiting for their response
    logic [1:0] pending;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pending <= '0;
        end else begin
            pending <= pending + 2'(dmem_req && dmem_req_ack)
                               - 2'(dmem_resp != mem_subsys_pkg::NOTRDY);
        end
    end

    // Response only in the cycle after the bus took the request
    assert property (@(posedge clk) disable iff (!rst_n)
        (dmem_resp != mem_subsys_pkg::NOTRDY) |-> $past(issue))
        else $error("response without a preceding address phase");

    assert property (@(posedge clk) !rst_n |=> (htrans == mem_subsys_pkg::IDLE) &&
        (dmem_resp == mem_subsys_pkg::NOTRDY) && dmem_req_ack)
        else $error("bridge not idle after reset");

    // One request in the buffer and one in its data phase at most
    assert property (@(posedge clk) disable iff (!rst_n) pending <= 2'd2)
        else $error("request buffer overflow");

endmodule

bind dmem_ahb_bridge dmem_bridge_checker u_checker (
    .clk          (clk),
    .rst_n        (rst_n),
    .issue        (issue),
    .dmem_req     (dmem_req),
    .dmem_req_ack (dmem_req_ack),
    .dmem_resp    (dmem_resp),
    .htrans       (bus.htrans)
);

/* testbench/mem_subsys_tb.sv */
/*
 * Memory subsystem testbench
 * Table-driven loads, stores and fetches checked against a byte-lane memory model
 */
`timescale 1ns/1ps

module mem_subsys_tb;

    localparam int CLK_PERIOD = 10;
    localparam int RESET_CYCLES = 8;
    localparam int CYCLES_PER_ROW = 20;

    // Row port selection
    localparam logic [1:0] P_IMEM = 2'd0;
    localparam logic [1:0] P_DMEM = 2'd1;
    localparam logic [1:0] P_BOTH = 2'd2;

    typedef struct packed {
        logic [1:0]                 port;
        mem_subsys_pkg::mem_cmd_e   cmd;
        mem_subsys_pkg::mem_width_e width;
        mem_subsys_pkg::bus_word_t  addr;
        mem_subsys_pkg::bus_word_t  wdata;
        mem_subsys_pkg::bus_word_t  iaddr;
        mem_subsys_pkg::mem_resp_e  resp;
        logic                       pipe;
    } row_t;

    typedef struct packed {
        mem_subsys_pkg::mem_resp_e resp;
        logic                      chk_data;
        mem_subsys_pkg::bus_word_t data;
    } expect_t;

    logic                       clk;
    logic                       rst_n;
    logic                       imem_req;
    mem_subsys_pkg::bus_word_t  imem_addr;
    logic                       imem_req_ack;
    mem_subsys_pkg::bus_word_t  imem_rdata;
    mem_subsys_pkg::mem_resp_e  imem_resp;
    logic                       dmem_req;
    mem_subsys_pkg::mem_cmd_e   dmem_cmd;
    mem_subsys_pkg::mem_width_e dmem_width;
    mem_subsys_pkg::bus_word_t  dmem_addr;
    mem_subsys_pkg::bus_word_t  dmem_wdata;
    logic                       dmem_req_ack;
    mem_subsys_pkg::bus_word_t  dmem_rdata;
    mem_subsys_pkg::mem_resp_e  dmem_resp;

    row_t                       table_q[$];
    expect_t                    i_exp_q[$];
    expect_t                    d_exp_q[$];
    mem_subsys_pkg::bus_word_t  model_mem [256];
    int                         errors;

    mem_subsys DUT (.*);

    always #(CLK_PERIOD / 2) clk = ~clk;

    // ------------------------------------------------------------------
    // Reference model and checking
    // ------------------------------------------------------------------
    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            errors++;
            $display("ERROR: %s got 0x%08h expected 0x%08h", name, got, exp);
            $display("CHECKS FAILED");
            $fatal(1, "stopping at first mismatch");
        end
    endtask

    // Stores merge lane by lane into the model word
    function automatic void store_model(input mem_subsys_pkg::mem_width_e width,
                                        input logic [31:0] addr, input logic [31:0] wdata);
        int idx;
        int lane;
        idx  = int'(addr[9:2]);
        lane = int'(addr[1:0]);
        for (int i = 0; i < 4; i++) begin
            if (width == mem_subsys_pkg::WORD) begin
                model_mem[idx][8*i +: 8] = wdata[8*i +: 8];
            end else if (width == mem_subsys_pkg::HWORD && (i / 2) == (lane / 2)) begin
                model_mem[idx][8*i +: 8] = wdata[8*(i % 2) +: 8];
            end else if (width == mem_subsys_pkg::BYTE && i == lane) begin
                model_mem[idx][8*i +: 8] = wdata[7:0];
            end
        end
    endfunction

    function automatic logic [31:0] load_model(input mem_subsys_pkg::mem_width_e width,
                                               input logic [31:0] addr);
        logic [31:0] word;
        int          lane;
        word = model_mem[int'(addr[9:2])];
        lane = int'(addr[1:0]);
        case (width)
            mem_subsys_pkg::BYTE:  return {24'h0, word[8*lane +: 8]};
            mem_subsys_pkg::HWORD: return {16'h0, word[16*(lane / 2) +: 16]};
            default:               return word;
        endcase
    endfunction

    task automatic add_row(input logic [1:0] port, input mem_subsys_pkg::mem_cmd_e cmd,
                           input mem_subsys_pkg::mem_width_e width, input logic [31:0] addr,
                           input logic [31:0] wdata, input logic [31:0] iaddr,
                           input mem_subsys_pkg::mem_resp_e resp, input logic pipe);
        row_t r;
        r = '{port, cmd, width, addr, wdata, iaddr, resp, pipe};
        table_q.push_back(r);
    endtask

    // Responses are stable away from the rising edge
    always @(negedge clk) begin
        expect_t e;
        if (rst_n && dmem_resp != mem_subsys_pkg::NOTRDY) begin
            if (d_exp_q.size() == 0) begin
                $display("Data port answered with no request outstanding");
                $display("CHECKS FAILED");
                $fatal(1, "unexpected response");
            end
            e = d_exp_q.pop_front();
            check_value("dmem_resp", 32'(dmem_resp), 32'(e.resp));
            if (e.chk_data) begin
                check_value("dmem_rdata", dmem_rdata, e.data);
            end
        end
        if (rst_n && imem_resp != mem_subsys_pkg::NOTRDY) begin
            if (i_exp_q.size() == 0) begin
                $display("Fetch port answered with no request outstanding");
                $display("CHECKS FAILED");
                $fatal(1, "unexpected response");
            end
            e = i_exp_q.pop_front();
            check_value("imem_resp", 32'(imem_resp), 32'(e.resp));
            if (e.chk_data) begin
                check_value("imem_rdata", imem_rdata, e.data);
            end
        end
    end

    // ------------------------------------------------------------------
    // Stimulus
    // ------------------------------------------------------------------
    initial begin
        row_t    r;
        expect_t e;
        logic    d_pend;
        logic    i_pend;
        clk        = 1'b0;
        rst_n      = 1'b0;
        errors     = 0;
        imem_req   = 1'b0;
        imem_addr  = '0;
        dmem_req   = 1'b0;
        dmem_cmd   = mem_subsys_pkg::RD;
        dmem_width = mem_subsys_pkg::WORD;
        dmem_addr  = '0;
        dmem_wdata = '0;

        // Lane merging of byte and halfword stores
        add_row(P_DMEM, mem_subsys_pkg::WR, mem_subsys_pkg::WORD, 32'h10, 32'h11223344,
                32'h0, mem_subsys_pkg::RDY_OK, 1'b0);
        add_row(P_DMEM, mem_subsys_pkg::WR, mem_subsys_pkg::BYTE, 32'h10, 32'h000000aa,
                32'h0, mem_subsys_pkg::RDY_OK, 1'b0);
        add_row(P_DMEM, mem_subsys_pkg::WR, mem_subsys_pkg::BYTE, 32'h11, 32'h000000bb,
                32'h0, mem_subsys_pkg::RDY_OK, 1'b0);
        add_row(P_DMEM, mem_subsys_pkg::WR, mem_subsys_pkg::BYTE, 32'h12, 32'h000000cc,
                32'h0, mem_subsys_pkg::RDY_OK, 1'b0);
        add_row(P_DMEM, mem_subsys_pkg::WR, mem_subsys_pkg::BYTE, 32'h13, 32'h000000dd,
                32'h0, mem_subsys_pkg::RDY_OK, 1'b0);
        add_row(P_DMEM, mem_subsys_pkg::RD, mem_subsys_pkg::WORD, 32'h10, 32'h0,
                32'h0, mem_subsys_pkg::RDY_OK, 1'b0);
        add_row(P_DMEM, mem_subsys_pkg::WR, mem_subsys_pkg::WORD, 32'h14, 32'h55667788,
                32'h0, mem_subsys_pkg::RDY_OK, 1'b0);
        add_row(P_DMEM, mem_subsys_pkg::WR, mem_subsys_pkg::HWORD, 32'h14, 32'h00001234,
                32'h0, mem_subsys_pkg::RDY_OK, 1'b0);
        add_row(P_DMEM, mem_subsys_pkg::WR, mem_subsys_pkg::HWORD, 32'h16, 32'h0000abcd,
                32'h0, mem_subsys_pkg::RDY_OK, 1'b0);
        add_row(P_DMEM, mem_subsys_pkg::RD, mem_subsys_pkg::WORD, 32'h14, 32'h0,
                32'h0, mem_subsys_pkg::RDY_OK, 1'b0);
        // Narrow loads
        add_row(P_DMEM, mem_subsys_pkg::RD, mem_subsys_pkg::BYTE, 32'h11, 32'h0,
                32'h0, mem_subsys_pkg::RDY_OK, 1'b0);
        add_row(P_DMEM, mem_subsys_pkg::RD, mem_subsys_pkg::BYTE, 32'h13, 32'h0,
                32'h0, mem_subsys_pkg::RDY_OK, 1'b0);
        add_row(P_DMEM, mem_subsys_pkg::RD, mem_subsys_pkg::HWORD, 32'h16, 32'h0,
                32'h0, mem_subsys_pkg::RDY_OK, 1'b0);
        add_row(P_DMEM, mem_subsys_pkg::RD, mem_subsys_pkg::HWORD, 32'h14, 32'h0,
                32'h0, mem_subsys_pkg::RDY_OK, 1'b0);
        // Fetch sees data written through the data port
        add_row(P_DMEM, mem_subsys_pkg::WR, mem_subsys_pkg::WORD, 32'h20, 32'hcafef00d,
                32'h0, mem_subsys_pkg::RDY_OK, 1'b0);
        add_row(P_IMEM, mem_subsys_pkg::RD, mem_subsys_pkg::WORD, 32'h0, 32'h0,
                32'h20, mem_subsys_pkg::RDY_OK, 1'b0);
        // Out of range, and 0x400 would alias word 0 if it were written
        add_row(P_DMEM, mem_subsys_pkg::WR, mem_subsys_pkg::WORD, 32'h0, 32'h01020304,
                32'h0, mem_subsys_pkg::RDY_OK, 1'b0);
        add_row(P_DMEM, mem_subsys_pkg::WR, mem_subsys_pkg::WORD, 32'h400, 32'hdeadbeef,
                32'h0, mem_subsys_pkg::RDY_ER, 1'b0);
        add_row(P_DMEM, mem_subsys_pkg::RD, mem_subsys_pkg::WORD, 32'h0, 32'h0,
                32'h0, mem_subsys_pkg::RDY_OK, 1'b0);
        add_row(P_IMEM, mem_subsys_pkg::RD, mem_subsys_pkg::WORD, 32'h0, 32'h0,
                32'h800, mem_subsys_pkg::RDY_ER, 1'b1);
        add_row(P_IMEM, mem_subsys_pkg::RD, mem_subsys_pkg::WORD, 32'h0, 32'h0,
                32'h0, mem_subsys_pkg::RDY_OK, 1'b0);
        add_row(P_DMEM, mem_subsys_pkg::RD, mem_subsys_pkg::WORD, 32'h10000000, 32'h0,
                32'h0, mem_subsys_pkg::RDY_ER, 1'b0);
        add_row(P_DMEM, mem_subsys_pkg::RD, mem_subsys_pkg::BYTE, 32'h12, 32'h0,
                32'h0, mem_subsys_pkg::RDY_OK, 1'b0);
        // Back to back, two transfers in flight
        add_row(P_DMEM, mem_subsys_pkg::WR, mem_subsys_pkg::WORD, 32'h30, 32'h0badcafe,
                32'h0, mem_subsys_pkg::RDY_OK, 1'b1);
        add_row(P_DMEM, mem_subsys_pkg::RD, mem_subsys_pkg::HWORD, 32'h32, 32'h0,
                32'h0, mem_subsys_pkg::RDY_OK, 1'b1);
        add_row(P_BOTH, mem_subsys_pkg::WR, mem_subsys_pkg::BYTE, 32'h31, 32'h0000005a,
                32'h10, mem_subsys_pkg::RDY_OK, 1'b1);
        add_row(P_BOTH, mem_subsys_pkg::RD, mem_subsys_pkg::WORD, 32'h30, 32'h0,
                32'h14, mem_subsys_pkg::RDY_OK, 1'b1);
        add_row(P_BOTH, mem_subsys_pkg::RD, mem_subsys_pkg::BYTE, 32'h13, 32'h0,
                32'h30, mem_subsys_pkg::RDY_OK, 1'b0);
        add_row(P_DMEM, mem_subsys_pkg::WR, mem_subsys_pkg::WORD, 32'h24, 32'h13579bdf,
                32'h0, mem_subsys_pkg::RDY_OK, 1'b1);
        add_row(P_DMEM, mem_subsys_pkg::RD, mem_subsys_pkg::WORD, 32'h24, 32'h0,
                32'h0, mem_subsys_pkg::RDY_OK, 1'b0);
        // Error in the pipeline with a request right behind it
        add_row(P_DMEM, mem_subsys_pkg::RD, mem_subsys_pkg::WORD, 32'h404, 32'h0,
                32'h0, mem_subsys_pkg::RDY_ER, 1'b1);
        add_row(P_DMEM, mem_subsys_pkg::RD, mem_subsys_pkg::WORD, 32'h20, 32'h0,
                32'h0, mem_subsys_pkg::RDY_OK, 1'b1);
        add_row(P_DMEM, mem_subsys_pkg::RD, mem_subsys_pkg::WORD, 32'h24, 32'h0,
                32'h0, mem_subsys_pkg::RDY_OK, 1'b0);

        // Watchdog
        fork
            begin
                #(CLK_PERIOD * (CYCLES_PER_ROW * table_q.size() + RESET_CYCLES + 4));
                $display("Timeout waiting for a response from the DUT");
                $display("CHECKS FAILED");
                $fatal(1, "watchdog expired");
            end
        join_none

        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        repeat (2) @(negedge clk);

        // Both buffers empty and accepting after reset
        check_value("dmem_req_ack", 32'(dmem_req_ack), 32'h1);
        check_value("imem_req_ack", 32'(imem_req_ack), 32'h1);

        foreach (table_q[n]) begin
            r          = table_q[n];
            d_pend     = (r.port != P_IMEM);
            i_pend     = (r.port != P_DMEM);
            dmem_req   = d_pend;
            dmem_cmd   = r.cmd;
            dmem_width = r.width;
            dmem_addr  = r.addr;
            dmem_wdata = r.wdata;
            imem_req   = i_pend;
            imem_addr  = r.iaddr;
            while (d_pend || i_pend) begin
                // The acknowledge is taken at the coming rising edge
                if (d_pend && dmem_req_ack) begin
                    if (r.resp == mem_subsys_pkg::RDY_OK && r.cmd == mem_subsys_pkg::WR) begin
                        store_model(r.width, r.addr, r.wdata);
                    end
                    e.resp     = r.resp;
                    e.chk_data = (r.resp == mem_subsys_pkg::RDY_OK) &&
                                 (r.cmd == mem_subsys_pkg::RD);
                    e.data     = load_model(r.width, r.addr);
                    d_exp_q.push_back(e);
                    d_pend = 1'b0;
                end
                if (i_pend && imem_req_ack) begin
                    e.resp     = (r.port == P_BOTH) ? mem_subsys_pkg::RDY_OK : r.resp;
                    e.chk_data = (e.resp == mem_subsys_pkg::RDY_OK);
                    e.data     = load_model(mem_subsys_pkg::WORD, r.iaddr);
                    i_exp_q.push_back(e);
                    i_pend = 1'b0;
                end
                @(negedge clk);
                dmem_req = d_pend;
                imem_req = i_pend;
            end
            if (!r.pipe) begin
                while (d_exp_q.size() != 0 || i_exp_q.size() != 0) begin
                    @(negedge clk);
                end
                // Nothing buffered once every response is in
                check_value("dmem_req_ack", 32'(dmem_req_ack), 32'h1);
                check_value("imem_req_ack", 32'(imem_req_ack), 32'h1);
            end
        end

        while (d_exp_q.size() != 0 || i_exp_q.size() != 0) begin
            @(negedge clk);
        end
        if (errors == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule
